// File: Makefile
# Verilator build and run for the cache testbench

VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wall -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "No errors" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: cache_store/cache_store.sv
/*
 * Tag, valid, dirty and data arrays
 * Four-way hit compare, LFSR victim choice, array write port
 */
`timescale 1ns/1ps

module cache_store import cache_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    lookup_if.store lk
);

    tag_t              tag_q   [NUM_SETS][WAYS];
    line_t             data_q  [NUM_SETS][WAYS];
    logic [WAYS-1:0]   valid_q [NUM_SETS];
    logic [WAYS-1:0]   dirty_q [NUM_SETS];
    logic [LFSR_W-1:0] lfsr_q;

    logic found_inv;   // Set has an empty way
    way_t inv_way;     // Lowest empty way

    // ==========================================================
    // Lookup
    // ==========================================================
    always_comb begin
        lk.hit     = 1'b0;
        lk.hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (valid_q[lk.set][w] && tag_q[lk.set][w] == lk.tag) begin
                lk.hit     = 1'b1;
                lk.hit_way = way_t'(w);
            end
        end
    end

    assign lk.hit_word = data_q[lk.set][lk.hit_way][lk.woff*DATA_W +: DATA_W];

    // Downward scan leaves the lowest empty way
    always_comb begin
        found_inv = 1'b0;
        inv_way   = '0;
        for (int w = WAYS-1; w >= 0; w--) begin
            if (!valid_q[lk.set][w]) begin
                found_inv = 1'b1;
                inv_way   = way_t'(w);
            end
        end
    end

    // Random way only once the set is full
    assign lk.victim_way   = found_inv ? inv_way : lfsr_q[WAY_W-1:0];
    assign lk.victim_valid = valid_q[lk.set][lk.victim_way];
    assign lk.victim_dirty = dirty_q[lk.set][lk.victim_way];
    assign lk.victim_tag   = tag_q[lk.set][lk.victim_way];
    assign lk.victim_line  = data_q[lk.set][lk.victim_way];

    // Free-running Fibonacci LFSR
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr_q <= LFSR_SEED;
        end else begin
            lfsr_q <= {lfsr_q[LFSR_W-2:0], ^(lfsr_q & LFSR_TAPS)};
        end
    end

    // ==========================================================
    // Write port
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (lk.wr_en) begin
            case (lk.wr_kind)
                WR_WORD: dirty_q[lk.wr_set][lk.wr_way] <= 1'b1;   // Write hit
                WR_LINE: begin
                    valid_q[lk.wr_set][lk.wr_way] <= 1'b1;
                    dirty_q[lk.wr_set][lk.wr_way] <= lk.wr_dirty; // Set for write-allocate
                end
                default: begin
                    // Victim stays out of lookups until its fill
                    valid_q[lk.wr_set][lk.wr_way] <= 1'b0;
                    dirty_q[lk.wr_set][lk.wr_way] <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (lk.wr_en && lk.wr_kind == WR_WORD) begin
            data_q[lk.wr_set][lk.wr_way][lk.wr_word_off*DATA_W +: DATA_W] <= lk.wr_word;
        end else if (lk.wr_en && lk.wr_kind == WR_LINE) begin
            tag_q[lk.wr_set][lk.wr_way]  <= lk.wr_tag;
            data_q[lk.wr_set][lk.wr_way] <= lk.wr_line;
        end
    end

endmodule

// File: common/cache_pkg.sv
/*
 * Cache geometry and address field widths
 * Shared vector typedefs, write port kinds, MSHR entry struct
 * Replacement LFSR constants
 */
package cache_pkg;

    // ==========================================================
    // Geometry
    // ==========================================================
    localparam int ADDR_W         = 20;                       // Byte address
    localparam int DATA_W         = 32;
    localparam int WORDS_PER_LINE = 8;
    localparam int LINE_W         = WORDS_PER_LINE * DATA_W;  // 32-byte line
    localparam int WORD_W         = 3;                        // Word offset in a line
    localparam int NUM_SETS       = 8;
    localparam int SET_W          = 3;
    localparam int TAG_W          = 12;                       // Above set and line offset
    localparam int BLOCK_W        = TAG_W + SET_W;            // Tag then set
    localparam int WAYS           = 4;
    localparam int WAY_W          = 2;
    localparam int NUM_MSHR       = 4;
    localparam int MSHR_W         = 2;
    localparam int ID_W           = 4;

    // Replacement LFSR, taps at bits 15, 13, 12 and 10
    localparam int                LFSR_W    = 16;
    localparam logic [LFSR_W-1:0] LFSR_SEED = 16'hACE1;
    localparam logic [LFSR_W-1:0] LFSR_TAPS = 16'hB400;

    // ==========================================================
    // Types
    // ==========================================================
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [DATA_W-1:0]  word_t;
    typedef logic [LINE_W-1:0]  line_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [SET_W-1:0]   set_t;
    typedef logic [BLOCK_W-1:0] block_t;
    typedef logic [WAY_W-1:0]   way_t;
    typedef logic [WORD_W-1:0]  woff_t;
    typedef logic [MSHR_W-1:0]  mshr_idx_t;
    typedef logic [ID_W-1:0]    req_id_t;

    typedef enum logic [1:0] {
        WR_WORD,   // One word, line turns dirty
        WR_LINE,   // Install a fetched line
        WR_INVAL   // Drop a way before its refill
    } wr_kind_t;

    // One outstanding miss
    typedef struct packed {
        block_t  block;      // Missed block
        woff_t   woff;
        logic    rw;         // 1 = write
        word_t   wdata;
        req_id_t id;
        way_t    way;        // Way that receives the fill
        logic    wb_needed;  // Dirty victim goes out first
        block_t  wb_block;
        line_t   wb_line;
    } mshr_entry_t;

endpackage

// File: common/lookup_if.sv
/*
 * Controller to tag and data store link
 * Lookup, victim candidate and array write port
 */
`timescale 1ns/1ps

interface lookup_if import cache_pkg::*; ();

    // Lookup, combinational from the CPU address
    set_t     set;
    tag_t     tag;
    woff_t    woff;
    logic     hit;
    way_t     hit_way;
    word_t    hit_word;      // Word at woff in the hit way

    // Victim candidate of the addressed set
    way_t     victim_way;
    logic     victim_valid;
    logic     victim_dirty;
    tag_t     victim_tag;
    line_t    victim_line;

    // Write port
    logic     wr_en;
    wr_kind_t wr_kind;
    set_t     wr_set;
    way_t     wr_way;
    woff_t    wr_word_off;   // WR_WORD only
    word_t    wr_word;
    tag_t     wr_tag;        // WR_LINE only
    line_t    wr_line;
    logic     wr_dirty;

    modport ctrl (
        output set, tag, woff,
        input  hit, hit_way, hit_word,
        input  victim_way, victim_valid, victim_dirty, victim_tag, victim_line,
        output wr_en, wr_kind, wr_set, wr_way, wr_word_off, wr_word,
        output wr_tag, wr_line, wr_dirty
    );

    modport store (
        input  set, tag, woff,
        output hit, hit_way, hit_word,
        output victim_way, victim_valid, victim_dirty, victim_tag, victim_line,
        input  wr_en, wr_kind, wr_set, wr_way, wr_word_off, wr_word,
        input  wr_tag, wr_line, wr_dirty
    );

endinterface

// File: common/mshr_if.sv
/*
 * Controller to MSHR file link
 * Set probe, entry allocation and fill delivery
 */
`timescale 1ns/1ps

interface mshr_if import cache_pkg::*; ();

    // Probe and allocation from the controller
    set_t        probe_set;
    logic        alloc_en;      // Takes the lowest free entry
    mshr_entry_t alloc_entry;

    // Status back to the controller
    logic        has_free;
    logic        set_busy;      // probe_set already has a pending miss

    // Fetch response, one cycle wide
    logic        fill_valid;
    mshr_entry_t fill_entry;
    line_t       fill_line;

    modport ctrl (
        output probe_set, alloc_en, alloc_entry,
        input  has_free, set_busy,
        input  fill_valid, fill_entry, fill_line
    );

    modport file (
        input  probe_set, alloc_en, alloc_entry,
        output has_free, set_busy,
        output fill_valid, fill_entry, fill_line
    );

endinterface

// File: mshr/mshr_file.sv
/*
 * Four-entry miss status holding register file
 * Free and same-set search, writeback then fetch sequencing
 * Single in-order memory request channel
 */
`timescale 1ns/1ps

module mshr_file import cache_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    mshr_if.file   mf,
    output logic   mem_req_valid,
    output logic   mem_req_rw,
    output block_t mem_req_addr,
    output line_t  mem_req_wdata,
    input  logic   mem_resp_valid,
    input  line_t  mem_resp_rdata
);

    mshr_entry_t         ent_q [NUM_MSHR];
    logic [NUM_MSHR-1:0] valid_q;    // Entry holds a miss
    logic [NUM_MSHR-1:0] issued_q;   // Its current step is on the bus
    logic [NUM_MSHR-1:0] wbp_q;      // Writeback still owed

    logic      busy_q;               // Memory transaction in flight
    mshr_idx_t fly_q;                // Entry that owns it
    logic      fly_wb_q;             // In-flight step is a writeback

    mshr_idx_t free_idx;
    mshr_idx_t pick_idx;             // Lowest entry waiting for the bus
    logic      pick_ok;

    // ==========================================================
    // Searches
    // ==========================================================
    always_comb begin
        mf.has_free = 1'b0;
        mf.set_busy = 1'b0;
        free_idx    = '0;
        pick_idx    = '0;
        pick_ok     = 1'b0;
        for (int i = NUM_MSHR-1; i >= 0; i--) begin   // Lowest index wins
            if (!valid_q[i]) begin
                mf.has_free = 1'b1;
                free_idx    = mshr_idx_t'(i);
            end
            if (valid_q[i] && !issued_q[i]) begin
                pick_ok  = 1'b1;
                pick_idx = mshr_idx_t'(i);
            end
            if (valid_q[i] && ent_q[i].block[SET_W-1:0] == mf.probe_set) begin
                mf.set_busy = 1'b1;
            end
        end
    end

    // Fetch data goes straight to the controller
    assign mf.fill_valid = mem_resp_valid && busy_q && !fly_wb_q;
    assign mf.fill_entry = ent_q[fly_q];
    assign mf.fill_line  = mem_resp_rdata;

    // ==========================================================
    // Entry state and bus sequencing
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q       <= '0;
            issued_q      <= '0;
            wbp_q         <= '0;
            busy_q        <= 1'b0;
            fly_q         <= '0;
            fly_wb_q      <= 1'b0;
            mem_req_valid <= 1'b0;
        end else begin
            mem_req_valid <= 1'b0;                      // One-cycle pulse
            if (mf.alloc_en) begin
                valid_q[free_idx]  <= 1'b1;
                issued_q[free_idx] <= 1'b0;
                wbp_q[free_idx]    <= mf.alloc_entry.wb_needed;
            end
            if (busy_q) begin
                if (mem_resp_valid) begin
                    busy_q          <= 1'b0;
                    issued_q[fly_q] <= 1'b0;
                    if (fly_wb_q) begin
                        wbp_q[fly_q] <= 1'b0;           // Fetch comes next
                    end else begin
                        valid_q[fly_q] <= 1'b0;         // Line handed over
                    end
                end
            end else if (pick_ok) begin
                mem_req_valid      <= 1'b1;
                busy_q             <= 1'b1;
                issued_q[pick_idx] <= 1'b1;
                fly_q              <= pick_idx;
                fly_wb_q           <= wbp_q[pick_idx];
            end
        end
    end

    // Entry payload and request fields
    always_ff @(posedge clk) begin
        if (mf.alloc_en) begin
            ent_q[free_idx] <= mf.alloc_entry;
        end
        if (!busy_q && pick_ok) begin
            mem_req_rw    <= wbp_q[pick_idx];
            mem_req_addr  <= wbp_q[pick_idx] ? ent_q[pick_idx].wb_block
                                             : ent_q[pick_idx].block;
            mem_req_wdata <= ent_q[pick_idx].wb_line;   // Ignored on a fetch
        end
    end

endmodule

// File: rtl/cache_ctrl.sv
/*
 * Cache controller
 * Accept decision, hit response, MSHR allocation, fill install
 */
`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    lookup_if.ctrl  lk,
    mshr_if.ctrl    mf,
    input  logic    cpu_req_valid,
    input  logic    cpu_req_rw,
    input  addr_t   cpu_req_addr,
    input  word_t   cpu_req_wdata,
    input  req_id_t cpu_req_id,
    output logic    cpu_req_ready,
    output logic    cpu_resp_valid,
    output logic    cpu_resp_hit,
    output word_t   cpu_resp_rdata,
    output req_id_t cpu_resp_id,
    input  logic    mem_resp_valid
);

    set_t  req_set;
    woff_t req_woff;
    logic  miss_ok;       // A miss could be taken this cycle
    logic  accept;
    line_t fill_merged;   // Fetched line with any store word in place

    // Address fields, word aligned
    assign req_woff = cpu_req_addr[2 +: WORD_W];
    assign req_set  = cpu_req_addr[WORD_W+2 +: SET_W];
    assign lk.set   = req_set;
    assign lk.tag   = cpu_req_addr[ADDR_W-1 -: TAG_W];
    assign lk.woff  = req_woff;

    // ==========================================================
    // Accept decision
    // ==========================================================
    assign mf.probe_set  = req_set;
    assign miss_ok       = mf.has_free && !mf.set_busy;
    assign cpu_req_ready = !mem_resp_valid && (lk.hit || miss_ok);  // Fill owns the arrays
    assign accept        = cpu_req_valid && cpu_req_ready;

    assign mf.alloc_en    = accept && !lk.hit;
    assign mf.alloc_entry = '{
        block:     cpu_req_addr[ADDR_W-1 -: BLOCK_W],
        woff:      req_woff,
        rw:        cpu_req_rw,
        wdata:     cpu_req_wdata,
        id:        cpu_req_id,
        way:       lk.victim_way,
        wb_needed: lk.victim_valid && lk.victim_dirty,
        wb_block:  {lk.victim_tag, req_set},
        wb_line:   lk.victim_line
    };

    // Write-allocate merge
    always_comb begin
        fill_merged = mf.fill_line;
        if (mf.fill_entry.rw) begin
            fill_merged[mf.fill_entry.woff*DATA_W +: DATA_W] = mf.fill_entry.wdata;
        end
    end

    // ==========================================================
    // Array write port
    // ==========================================================
    always_comb begin
        lk.wr_en       = 1'b0;
        lk.wr_kind     = WR_WORD;
        lk.wr_set      = req_set;
        lk.wr_way      = lk.hit_way;
        lk.wr_word_off = req_woff;
        lk.wr_word     = cpu_req_wdata;
        lk.wr_tag      = mf.fill_entry.block[BLOCK_W-1 -: TAG_W];
        lk.wr_line     = fill_merged;
        lk.wr_dirty    = mf.fill_entry.rw;
        if (mf.fill_valid) begin
            lk.wr_en   = 1'b1;
            lk.wr_kind = WR_LINE;
            lk.wr_set  = mf.fill_entry.block[SET_W-1:0];
            lk.wr_way  = mf.fill_entry.way;
        end else if (accept && lk.hit) begin
            lk.wr_en   = cpu_req_rw;            // Read hits leave the arrays alone
        end else if (accept) begin
            lk.wr_en   = 1'b1;                  // Victim line already copied
            lk.wr_kind = WR_INVAL;
            lk.wr_way  = lk.victim_way;
        end
    end

    // ==========================================================
    // Response
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cpu_resp_valid <= 1'b0;
        end else begin
            cpu_resp_valid <= mf.fill_valid || (accept && lk.hit);
        end
    end

    // Fill and accept never share a cycle
    always_ff @(posedge clk) begin
        if (mf.fill_valid) begin
            cpu_resp_hit   <= 1'b0;
            cpu_resp_rdata <= fill_merged[mf.fill_entry.woff*DATA_W +: DATA_W];
            cpu_resp_id    <= mf.fill_entry.id;
        end else if (accept && lk.hit) begin
            cpu_resp_hit   <= 1'b1;
            cpu_resp_rdata <= cpu_req_rw ? cpu_req_wdata : lk.hit_word;
            cpu_resp_id    <= cpu_req_id;
        end
    end

endmodule

// File: rtl/cache_top.sv
/*
 * Non-blocking 4-way write-back cache top level
 * Store, MSHR file and controller joined by two interfaces
 */
`timescale 1ns/1ps

module cache_top import cache_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    // CPU side, valid with ready
    input  logic    cpu_req_valid,
    output logic    cpu_req_ready,
    input  logic    cpu_req_rw,       // 1 = write
    input  addr_t   cpu_req_addr,
    input  word_t   cpu_req_wdata,
    input  req_id_t cpu_req_id,
    output logic    cpu_resp_valid,
    output logic    cpu_resp_hit,
    output word_t   cpu_resp_rdata,
    output req_id_t cpu_resp_id,
    // Memory side, one request in flight
    output logic    mem_req_valid,
    output logic    mem_req_rw,       // 1 = writeback
    output block_t  mem_req_addr,
    output line_t   mem_req_wdata,
    input  logic    mem_resp_valid,
    input  line_t   mem_resp_rdata
);

    lookup_if lk ();
    mshr_if   mf ();

    cache_store u_store (
        .clk   (clk),
        .rst_n (rst_n),
        .lk    (lk)
    );

    mshr_file u_mshr (
        .clk            (clk),
        .rst_n          (rst_n),
        .mf             (mf),
        .mem_req_valid  (mem_req_valid),
        .mem_req_rw     (mem_req_rw),
        .mem_req_addr   (mem_req_addr),
        .mem_req_wdata  (mem_req_wdata),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_rdata (mem_resp_rdata)
    );

    cache_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .lk             (lk),
        .mf             (mf),
        .cpu_req_valid  (cpu_req_valid),
        .cpu_req_rw     (cpu_req_rw),
        .cpu_req_addr   (cpu_req_addr),
        .cpu_req_wdata  (cpu_req_wdata),
        .cpu_req_id     (cpu_req_id),
        .cpu_req_ready  (cpu_req_ready),
        .cpu_resp_valid (cpu_resp_valid),
        .cpu_resp_hit   (cpu_resp_hit),
        .cpu_resp_rdata (cpu_resp_rdata),
        .cpu_resp_id    (cpu_resp_id),
        .mem_resp_valid (mem_resp_valid)
    );

endmodule

// File: sources.f
common/cache_pkg.sv
common/lookup_if.sv
common/mshr_if.sv
cache_store/cache_store.sv
mshr/mshr_file.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
test/tb_clock.sv
test/cache_properties.sv
test/cache_tb.sv

// File: test/cache_properties.sv
/*
 * Concurrent assertions for the cache top level
 * Memory channel ordering, fill stall, response ID known
 */
`timescale 1ns/1ps

module cache_properties import cache_pkg::*; (
    input logic    clk,
    input logic    rst_n,
    input logic    mem_req_valid,
    input logic    mem_resp_valid,
    input logic    cpu_req_ready,
    input logic    cpu_resp_valid,
    input req_id_t cpu_resp_id
);

    logic waiting;   // Memory request not yet answered

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            waiting <= 1'b0;
        end else if (mem_req_valid) begin
            waiting <= 1'b1;
        end else if (mem_resp_valid) begin
            waiting <= 1'b0;
        end
    end

    // One transaction on the memory channel at a time
    one_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid |-> !waiting)
        else $error("second memory request before the first was answered");

    // A fill owns the arrays for its cycle
    fill_stalls_cpu: assert property (@(posedge clk) disable iff (!rst_n)
        mem_resp_valid |-> !cpu_req_ready)
        else $error("CPU request ready during a fill");

    resp_id_known: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_resp_valid |-> !$isunknown(cpu_resp_id))
        else $error("CPU response with an unknown ID");

endmodule

bind cache_top cache_properties u_props (.*);

// File: test/cache_tb.sv
/*
 * Cache testbench top with stimulus table and memory model
 * Reference word model, response scoreboard, compare tasks, timeout
 */
`timescale 1ns/1ps

module cache_tb import cache_pkg::*; ();

    localparam int NUM_TESTS = 23;
    localparam int MAX_CYCLES = NUM_TESTS * 40;
    // Expected hit result, HIT_UNDER also needs misses still pending
    localparam logic [1:0] MISS = 2'd0, HIT = 2'd1, ANY = 2'd2, HIT_UNDER = 2'd3;

    typedef struct {
        logic       rw;
        addr_t      addr;
        word_t      wdata;
        logic [1:0] hit_mode;
    } stim_t;

    logic clk, rst_n;
    logic cpu_req_valid, cpu_req_ready, cpu_req_rw;
    addr_t cpu_req_addr;
    word_t cpu_req_wdata;
    req_id_t cpu_req_id;
    logic cpu_resp_valid, cpu_resp_hit;
    word_t cpu_resp_rdata;
    req_id_t cpu_resp_id;
    logic mem_req_valid, mem_req_rw, mem_resp_valid;
    block_t mem_req_addr;
    line_t mem_req_wdata, mem_resp_rdata;

    stim_t  stim_q[$];
    line_t  mem_lines[block_t];   // Written-back lines
    word_t  ref_words[int];       // Flat model by word address
    word_t  exp_data[16];
    logic [1:0] exp_mode[16];
    logic   pending[16];
    req_id_t last_acc_id;
    int outstanding = 0, responses = 0, wb_count = 0, cycles = 0;
    int delay = 0;
    logic   m_rw;
    block_t m_addr;

    tb_clock u_clk (.clk(clk), .rst_n(rst_n));

    cache_top UUT (.*);

    // ============================================================
    // Helpers
    // ============================================================
    function automatic word_t pattern(logic [ADDR_W-3:0] wa);
        return {wa[13:0], wa};    // Whole word address in the word
    endfunction

    function automatic addr_t mk_addr(tag_t t, set_t s, woff_t w);
        return {t, s, w, 2'b00};
    endfunction

    function automatic line_t read_line(block_t b);
        line_t l;
        if (mem_lines.exists(b)) return mem_lines[b];
        for (int w = 0; w < WORDS_PER_LINE; w++)
            l[w*DATA_W +: DATA_W] = pattern({b, woff_t'(w)});
        return l;
    endfunction

    function automatic word_t ref_read(addr_t a);
        if (ref_words.exists(int'(a[ADDR_W-1:2]))) return ref_words[int'(a[ADDR_W-1:2])];
        return pattern(a[ADDR_W-1:2]);
    endfunction

    task automatic add(logic rw, addr_t a, word_t d, logic [1:0] m);
        stim_t s;
        s = '{rw: rw, addr: a, wdata: d, hit_mode: m};
        stim_q.push_back(s);
    endtask

    task automatic stop_run();
        $display("Errors found");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(word_t got, word_t exp, req_id_t id);
        if (got !== exp) begin
            $display("Error at %0t: rdata for ID %0d is %h, expected %h", $time, id, got, exp);
            stop_run();
        end
    endtask

    task automatic check_hit(logic got, logic exp, req_id_t id);
        if (got !== exp) begin
            $display("Error at %0t: hit for ID %0d is %b, expected %b", $time, id, got, exp);
            stop_run();
        end
    endtask

    task automatic check_id(req_id_t got, req_id_t exp);
        if (got !== exp) begin
            $display("Error at %0t: hit response ID is %0d, expected %0d", $time, got, exp);
            stop_run();
        end
    endtask

    // ============================================================
    // Memory model, answers after 2 to 6 cycles
    // ============================================================
    initial begin
        void'($urandom(48966));   // Seeds the delay draws below
        mem_resp_valid = 1'b0;
        mem_resp_rdata = '0;
        forever begin
            @(negedge clk);
            mem_resp_valid <= 1'b0;
            if (mem_req_valid) begin
                m_rw   = mem_req_rw;
                m_addr = mem_req_addr;
                if (mem_req_rw) begin
                    mem_lines[mem_req_addr] = mem_req_wdata;
                    wb_count++;
                end
                delay = 2 + $urandom % 5;
            end else if (delay > 0) begin
                delay--;
                if (delay == 0) begin
                    mem_resp_valid <= 1'b1;
                    mem_resp_rdata <= m_rw ? '0 : read_line(m_addr);   // Writeback only acked
                end
            end
        end
    end

    // Response scoreboard
    always @(negedge clk) begin
        if (rst_n && cpu_resp_valid) begin
            if (!pending[cpu_resp_id]) begin
                $display("Response with ID %0d arrived with no request outstanding", cpu_resp_id);
                stop_run();
            end
            // Fetch response still on the bus in this sample
            if (!cpu_resp_hit && !(mem_resp_valid && !mem_req_rw)) begin
                $display("Miss response for ID %0d did not follow its fill by one cycle",
                         cpu_resp_id);
                stop_run();
            end
            if (cpu_resp_hit) check_id(cpu_resp_id, last_acc_id);   // One cycle after accept
            check_word(cpu_resp_rdata, exp_data[cpu_resp_id], cpu_resp_id);
            if (exp_mode[cpu_resp_id] != ANY)
                check_hit(cpu_resp_hit, exp_mode[cpu_resp_id] != MISS, cpu_resp_id);
            pending[cpu_resp_id] = 1'b0;
            outstanding--;
            responses++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: only %0d of %0d responses after %0d cycles",
                     responses, NUM_TESTS, cycles);
            stop_run();
        end
    end

    // ============================================================
    // Stimulus
    // ============================================================
    initial begin
        stim_t s;
        req_id_t id;
        cpu_req_valid = 1'b0;
        cpu_req_rw = 1'b0;
        cpu_req_addr = '0;
        cpu_req_wdata = '0;
        cpu_req_id = '0;
        for (int i = 0; i < 16; i++) pending[i] = 1'b0;

        add(0, mk_addr(12'h001, 3'd0, 3'd2), '0, MISS);     // Untouched read
        add(0, mk_addr(12'h001, 3'd0, 3'd2), '0, HIT);      // Refetch hits
        add(1, mk_addr(12'h002, 3'd1, 3'd3), 32'hDEAD_0001, MISS);
        add(0, mk_addr(12'h002, 3'd1, 3'd3), '0, HIT);
        add(1, mk_addr(12'h002, 3'd1, 3'd3), 32'hBEEF_0002, HIT);
        add(0, mk_addr(12'h002, 3'd1, 3'd3), '0, HIT);
        for (int t = 3; t < 9; t++)                         // Six blocks in set 5
            add(1, mk_addr(tag_t'(t), 3'd5, 3'd1), 32'h5A00_0000 + t, MISS);
        for (int t = 3; t < 9; t++)
            add(0, mk_addr(tag_t'(t), 3'd5, 3'd1), '0, ANY);
        add(0, mk_addr(12'h009, 3'd2, 3'd0), '0, MISS);     // Four sets in flight
        add(0, mk_addr(12'h009, 3'd3, 3'd4), '0, MISS);
        add(0, mk_addr(12'h009, 3'd4, 3'd5), '0, MISS);
        add(0, mk_addr(12'h009, 3'd6, 3'd6), '0, MISS);
        add(0, mk_addr(12'h001, 3'd0, 3'd7), '0, HIT_UNDER);  // Hit under misses

        wait (rst_n);
        @(negedge clk);
        for (int i = 0; i < NUM_TESTS; i++) begin
            s  = stim_q[i];
            id = req_id_t'(i % 16);
            while (outstanding >= 16 || pending[id]) begin
                cpu_req_valid = 1'b0;   // Nothing offered while the ID is busy
                @(negedge clk);
            end
            cpu_req_valid = 1'b1;
            cpu_req_rw    = s.rw;
            cpu_req_addr  = s.addr;
            cpu_req_wdata = s.wdata;
            cpu_req_id    = id;
            #1;
            while (!cpu_req_ready) begin
                @(negedge clk);
                #1;
            end
            // Accepted at the coming rising edge
            if (s.rw) begin
                ref_words[int'(s.addr[ADDR_W-1:2])] = s.wdata;
                exp_data[id] = s.wdata;
            end else begin
                exp_data[id] = ref_read(s.addr);
            end
            if (s.hit_mode == HIT_UNDER && outstanding == 0) begin
                $display("Hit at table entry %0d was not accepted under pending misses", i);
                stop_run();
            end
            exp_mode[id] = s.hit_mode;
            pending[id]  = 1'b1;
            last_acc_id  = id;
            outstanding++;
            @(negedge clk);
        end
        cpu_req_valid = 1'b0;

        while (responses < NUM_TESTS) @(negedge clk);
        if (wb_count == 0) begin
            $display("No dirty writeback reached memory");
            stop_run();
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

// File: test/tb_clock.sv
/*
 * Testbench clock and reset source
 * 10 ns period, reset low for 5 cycles
 */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial clk = 1'b0;
    always #5 clk = ~clk;   // 10 ns period

    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);     // Release away from the active edge
        rst_n = 1'b1;
    end

endmodule
